/* carBus.sv */
// Car position bus carrying the X of all eight cars from lanes to readers
`timescale 1ns/1ps
`default_nettype none

interface carBus;

    // Lane 0
    froggerPkg::xPos_t car0X;
    froggerPkg::xPos_t car1X;
    // Lane 1
    froggerPkg::xPos_t car2X;
    froggerPkg::xPos_t car3X;
    // Lane 2
    froggerPkg::xPos_t car4X;
    froggerPkg::xPos_t car5X;
    // Lane 3
    froggerPkg::xPos_t car6X;
    froggerPkg::xPos_t car7X;

    // Lane controller side
    modport driver (output car0X, car1X, car2X, car3X, car4X, car5X, car6X, car7X);
    // Collision side
    modport reader (input car0X, car1X, car2X, car3X, car4X, car5X, car6X, car7X);

endinterface

`default_nettype wire

/* carLanes.sv */
// Lane controller moving eight cars per tick and wrapping them at the field edge
`timescale 1ns/1ps
`default_nettype none

module carLanes (
    input  wire logic   i_Clk,
    input  wire logic   i_rst,
    // Qualified game tick
    input  wire logic   i_step,
    carBus.driver       bus
);

    ////////////////////
    // Per-car movers
    ////////////////////

    for (genvar k = 0; k < froggerPkg::NUM_CARS; k++)
    begin : gCar
        froggerPkg::xPos_t carReg;
        froggerPkg::xPos_t nextX;

        // Direction fixed per lane, picked at elaboration
        if (froggerPkg::LANE_DIR_RIGHT[k / 2])
        begin : gRight
            froggerPkg::xPos_t stepSum;
            // Max 639 + 16, no overflow in 10 bits
            assign stepSum = carReg + froggerPkg::xPos_t'(froggerPkg::LANE_SPEED[k / 2]);
            // Past the right edge, back to the left
            assign nextX = (int'(stepSum) >= froggerPkg::FIELD_W)
                         ? stepSum - froggerPkg::xPos_t'(froggerPkg::FIELD_W)
                         : stepSum;
        end
        else
        begin : gLeft
            froggerPkg::xPos_t baseX;
            // Would go negative, lift by one field width first
            assign baseX = (int'(carReg) < froggerPkg::LANE_SPEED[k / 2])
                         ? carReg + froggerPkg::xPos_t'(froggerPkg::FIELD_W)
                         : carReg;
            assign nextX = baseX - froggerPkg::xPos_t'(froggerPkg::LANE_SPEED[k / 2]);
        end

        always_ff @(posedge i_Clk)
        begin
            if (i_rst)
                carReg <= froggerPkg::xPos_t'(froggerPkg::CAR_START_X[k]);
            else if (i_step)
                carReg <= nextX;
        end
    end

    ////////////////////
    // Bus drive
    ////////////////////

    // Lane 0
    assign bus.car0X = gCar[0].carReg;
    assign bus.car1X = gCar[1].carReg;
    // Lane 1
    assign bus.car2X = gCar[2].carReg;
    assign bus.car3X = gCar[3].carReg;
    // Lane 2
    assign bus.car4X = gCar[4].carReg;
    assign bus.car5X = gCar[5].carReg;
    // Lane 3
    assign bus.car6X = gCar[6].carReg;
    assign bus.car7X = gCar[7].carReg;

endmodule

`default_nettype wire

/* collisionCheck.sv */
// Collision checker testing the frog against all eight cars, registered hit out
`timescale 1ns/1ps
`default_nettype none

module collisionCheck (
    input  wire logic               i_Clk,
    input  wire logic               i_rst,
    // Frog top-left corner
    input  wire froggerPkg::xPos_t  i_frogX,
    input  wire froggerPkg::yPos_t  i_frogY,
    carBus.reader                   bus,
    output logic                    o_hit
);

    froggerPkg::xPos_t carX [froggerPkg::NUM_CARS];
    logic              anyHit;

    // One car against the frog, no wrap-around
    function automatic logic carOverlap(
        input froggerPkg::xPos_t frogX,
        input froggerPkg::yPos_t frogY,
        input froggerPkg::xPos_t carPos,
        input int                laneY
    );
        logic [10:0] frogL;
        logic [10:0] frogR;
        logic [10:0] carL;
        logic [10:0] carR;
        logic        rowHit;
        logic        colHit;
        // Widen by one bit, right edges reach 671
        frogL  = {1'b0, frogX};
        frogR  = frogL + 11'(froggerPkg::TILE_SIZE);
        carL   = {1'b0, carPos};
        carR   = carL + 11'(froggerPkg::TILE_SIZE);
        rowHit = (int'(frogY) >= laneY) && (int'(frogY) < laneY + froggerPkg::TILE_SIZE);
        // Left corner inside car, or right corner inside car
        colHit = ((frogL >= carL) && (frogL < carR)) || ((frogR >= carL) && (frogR < carR));
        return rowHit && colHit;
    endfunction

    // Bus members into an indexable array
    assign carX[0] = bus.car0X;
    assign carX[1] = bus.car1X;
    assign carX[2] = bus.car2X;
    assign carX[3] = bus.car3X;
    assign carX[4] = bus.car4X;
    assign carX[5] = bus.car5X;
    assign carX[6] = bus.car6X;
    assign carX[7] = bus.car7X;

    // OR over every car, each with its own lane row
    always_comb
    begin
        anyHit = 1'b0;
        for (int k = 0; k < froggerPkg::NUM_CARS; k++)
            anyHit |= carOverlap(i_frogX, i_frogY, carX[k], froggerPkg::LANE_Y[k / 2]);
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
            o_hit <= 1'b0;
        else
            o_hit <= anyHit;
    end

endmodule

`default_nettype wire

/* filelist.f */
froggerPkg.sv
carBus.sv
frogMover.sv
carLanes.sv
collisionCheck.sv
gameState.sv
froggerCore.sv
froggerCore_chk.sv
froggerCore_tb.sv

/* frogMover.sv */
// Frog mover stepping one tile per qualified tick with clamping and respawn
`timescale 1ns/1ps
`default_nettype none

module frogMover (
    input  wire logic               i_Clk,
    input  wire logic               i_rst,
    // Qualified game tick
    input  wire logic               i_step,
    // Direction buttons, levels
    input  wire logic               i_up,
    input  wire logic               i_down,
    input  wire logic               i_left,
    input  wire logic               i_right,
    // Single-cycle pulse from game state
    input  wire logic               i_respawn,
    output froggerPkg::xPos_t       o_frogX,
    output froggerPkg::yPos_t       o_frogY
);

    froggerPkg::xPos_t nextX;
    froggerPkg::yPos_t nextY;

    ////////////////////
    // Step decode
    ////////////////////

    // Priority up, down, left, right
    always_comb
    begin
        nextX = o_frogX;
        nextY = o_frogY;
        if (i_up)
        begin
            // Clamp at top row
            if (int'(o_frogY) >= froggerPkg::TILE_SIZE)
                nextY = o_frogY - froggerPkg::yPos_t'(froggerPkg::TILE_SIZE);
            else
                nextY = '0;
        end
        else if (i_down)
        begin
            if (int'(o_frogY) >= froggerPkg::FROG_Y_MAX)
                nextY = froggerPkg::yPos_t'(froggerPkg::FROG_Y_MAX);
            else
                nextY = o_frogY + froggerPkg::yPos_t'(froggerPkg::TILE_SIZE);
        end
        else if (i_left)
        begin
            if (int'(o_frogX) >= froggerPkg::TILE_SIZE)
                nextX = o_frogX - froggerPkg::xPos_t'(froggerPkg::TILE_SIZE);
            else
                nextX = '0;
        end
        else if (i_right)
        begin
            // Right edge keeps the full tile on screen
            if (int'(o_frogX) >= froggerPkg::FROG_X_MAX)
                nextX = froggerPkg::xPos_t'(froggerPkg::FROG_X_MAX);
            else
                nextX = o_frogX + froggerPkg::xPos_t'(froggerPkg::TILE_SIZE);
        end
    end

    ////////////////////
    // Position register
    ////////////////////

    always_ff @(posedge i_Clk)
    begin
        if (i_rst || i_respawn)
        begin
            // Respawn wins over a step in the same cycle
            o_frogX <= froggerPkg::xPos_t'(froggerPkg::FROG_START_X);
            o_frogY <= froggerPkg::yPos_t'(froggerPkg::FROG_START_Y);
        end
        else if (i_step)
        begin
            o_frogX <= nextX;
            o_frogY <= nextY;
        end
    end

endmodule

`default_nettype wire

/* froggerCore.sv */
// Frogger playfield top level connecting frog, lanes, collision and game state
`timescale 1ns/1ps
`default_nettype none

module froggerCore (
    input  wire logic                   i_Clk,
    input  wire logic                   i_rst,
    // Game tick pulse from outside
    input  wire logic                   i_tick,
    // Debounced buttons
    input  wire logic                   i_up,
    input  wire logic                   i_down,
    input  wire logic                   i_left,
    input  wire logic                   i_right,
    output froggerPkg::xPos_t           o_frogX,
    output froggerPkg::yPos_t           o_frogY,
    output froggerPkg::carPosArr_t      o_carX,
    output logic                        o_hit,
    output froggerPkg::lives_t          o_lives,
    output froggerPkg::score_t          o_score,
    output logic                        o_gameOver
);

    logic stepTick;
    logic respawn;

    carBus carBus_i ();

    ////////////////////
    // Frog and cars
    ////////////////////

    frogMover frogMover_i (
        .i_Clk     (i_Clk),
        .i_rst     (i_rst),
        .i_step    (stepTick),
        .i_up      (i_up),
        .i_down    (i_down),
        .i_left    (i_left),
        .i_right   (i_right),
        .i_respawn (respawn),
        .o_frogX   (o_frogX),
        .o_frogY   (o_frogY)
    );

    carLanes carLanes_i (
        .i_Clk  (i_Clk),
        .i_rst  (i_rst),
        .i_step (stepTick),
        .bus    (carBus_i)
    );

    ////////////////////
    // Rules
    ////////////////////

    collisionCheck collisionCheck_i (
        .i_Clk   (i_Clk),
        .i_rst   (i_rst),
        .i_frogX (o_frogX),
        .i_frogY (o_frogY),
        .bus     (carBus_i),
        .o_hit   (o_hit)
    );

    gameState gameState_i (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_tick     (i_tick),
        .i_hit      (o_hit),
        .i_frogY    (o_frogY),
        .o_stepTick (stepTick),
        .o_respawn  (respawn),
        .o_lives    (o_lives),
        .o_score    (o_score),
        .o_gameOver (o_gameOver)
    );

    // Car positions packed for the outside, element k is car k
    assign o_carX[0] = carBus_i.car0X;
    assign o_carX[1] = carBus_i.car1X;
    assign o_carX[2] = carBus_i.car2X;
    assign o_carX[3] = carBus_i.car3X;
    assign o_carX[4] = carBus_i.car4X;
    assign o_carX[5] = carBus_i.car5X;
    assign o_carX[6] = carBus_i.car6X;
    assign o_carX[7] = carBus_i.car7X;

endmodule

`default_nettype wire

/* froggerCore_chk.sv */
// Bound checker on the playfield outputs for lives, freeze after game over and hit sanity
`timescale 1ns/1ps
`default_nettype none

module froggerCore_chk (
    input wire logic                    i_Clk,
    input wire logic                    i_rst,
    input wire froggerPkg::lives_t      i_lives,
    input wire logic                    i_gameOver,
    input wire froggerPkg::xPos_t       i_frogX,
    input wire froggerPkg::carPosArr_t  i_carX,
    input wire logic                    i_hit
);

    // Failed assertions so far, read by the testbench
    int failCount = 0;

    // Lives only count down between resets
    livesNoRise: assert property (@(posedge i_Clk) disable iff (i_rst)
        i_lives <= $past(i_lives))
    else
    begin
        failCount++;
        $error("lives rose without a reset");
    end

    // Frozen field once the game is over
    frozenAfterOver: assert property (@(posedge i_Clk) disable iff (i_rst)
        (i_gameOver && $past(i_gameOver)) |-> ($stable(i_frogX) && $stable(i_carX)))
    else
    begin
        failCount++;
        $error("frog or cars moved after game over");
    end

    // Hit always resolved out of reset
    hitKnown: assert property (@(posedge i_Clk) disable iff (i_rst)
        !$isunknown(i_hit))
    else
    begin
        failCount++;
        $error("hit output is unknown");
    end

endmodule

`default_nettype wire

/* froggerCore_tb.sv */
// Directed testbench for the Frogger playfield with a reference model of the game rules
`timescale 1ns/1ps
`default_nettype none

module froggerCore_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int TICK_GAP     = 8;
    localparam int TILE         = froggerPkg::TILE_SIZE;
    localparam int GOAL_LIMIT   = 120;
    localparam int KILL_LIMIT   = 150;
    localparam int FROZEN_TICKS = 5;
    // Walk, car run, random play and the two bounded loops
    localparam int MAX_TICKS    = 36 + 200 + 120 + GOAL_LIMIT + KILL_LIMIT + FROZEN_TICKS;
    // Slack covers the resets between tests
    localparam int WATCHDOG_NS  = MAX_TICKS * TICK_GAP * CLK_PERIOD + 2000;

    // Button codes {up, down, left, right}
    localparam logic [3:0] BTN_NONE  = 4'b0000;
    localparam logic [3:0] BTN_UP    = 4'b1000;
    localparam logic [3:0] BTN_DOWN  = 4'b0100;
    localparam logic [3:0] BTN_LEFT  = 4'b0010;
    localparam logic [3:0] BTN_RIGHT = 4'b0001;

    logic                       i_Clk;
    logic                       i_rst;
    logic                       i_tick;
    logic                       i_up;
    logic                       i_down;
    logic                       i_left;
    logic                       i_right;
    froggerPkg::xPos_t          o_frogX;
    froggerPkg::yPos_t          o_frogY;
    froggerPkg::carPosArr_t     o_carX;
    logic                       o_hit;
    froggerPkg::lives_t         o_lives;
    froggerPkg::score_t         o_score;
    logic                       o_gameOver;

    // Reference model state
    int          mFrogX;
    int          mFrogY;
    int          mCarX [froggerPkg::NUM_CARS];
    int          mLives;
    int          mScore;
    bit          mGameOver;
    bit          mHit;
    int          errCount;
    int          checkCount;
    logic [31:0] rngState;

    froggerCore dut_i (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_tick     (i_tick),
        .i_up       (i_up),
        .i_down     (i_down),
        .i_left     (i_left),
        .i_right    (i_right),
        .o_frogX    (o_frogX),
        .o_frogY    (o_frogY),
        .o_carX     (o_carX),
        .o_hit      (o_hit),
        .o_lives    (o_lives),
        .o_score    (o_score),
        .o_gameOver (o_gameOver)
    );

    bind froggerCore froggerCore_chk chk_i (
        .i_Clk      (i_Clk),
        .i_rst      (i_rst),
        .i_lives    (o_lives),
        .i_gameOver (o_gameOver),
        .i_frogX    (o_frogX),
        .i_carX     (o_carX),
        .i_hit      (o_hit)
    );

    initial
    begin
        i_Clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_Clk = ~i_Clk;
    end

    ////////////////////
    // Model
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Car X one tick later modulo the field width
    function automatic int carNext(input int x, input int k);
        int speed;
        speed = froggerPkg::LANE_SPEED[k / 2];
        if (froggerPkg::LANE_DIR_RIGHT[k / 2])
            return (x + speed) % froggerPkg::FIELD_W;
        else
            return (x - speed + froggerPkg::FIELD_W) % froggerPkg::FIELD_W;
    endfunction

    // Vertical buttons win over horizontal ones
    function automatic int frogNextX(input int x, input logic [3:0] btn);
        if (btn[3] || btn[2])
            return x;
        if (btn[1])
            return (x >= TILE) ? x - TILE : 0;
        if (btn[0])
            return (x + TILE > froggerPkg::FROG_X_MAX) ? froggerPkg::FROG_X_MAX : x + TILE;
        return x;
    endfunction

    function automatic int frogNextY(input int y, input logic [3:0] btn);
        if (btn[3])
            return (y >= TILE) ? y - TILE : 0;
        if (btn[2])
            return (y + TILE > froggerPkg::FROG_Y_MAX) ? froggerPkg::FROG_Y_MAX : y + TILE;
        return y;
    endfunction

    // Overlap of a frog at (fx, fy) with any car now or one tick ahead
    function automatic bit hitsAt(input int fx, input int fy, input bit ahead);
        int cx;
        int ly;
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < froggerPkg::NUM_CARS; k++)
        begin
            cx = ahead ? carNext(mCarX[k], k) : mCarX[k];
            ly = froggerPkg::LANE_Y[k / 2];
            if (fy >= ly && fy < ly + TILE)
            begin
                if ((fx >= cx && fx < cx + TILE) || (fx + TILE >= cx && fx + TILE < cx + TILE))
                    hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // First candidate whose hit outcome matches or the fallback
    function automatic logic [3:0] pickMove(input bit wantHit, input logic [3:0] fallback);
        logic [3:0] cand [5];
        logic [3:0] pick;
        bit         found;
        cand  = '{BTN_UP, BTN_NONE, BTN_LEFT, BTN_RIGHT, BTN_DOWN};
        pick  = fallback;
        found = 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            if (!found && hitsAt(frogNextX(mFrogX, cand[i]), frogNextY(mFrogY, cand[i]), 1'b1)
                          == wantHit)
            begin
                pick  = cand[i];
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    task automatic modelReset();
        mFrogX    = froggerPkg::FROG_START_X;
        mFrogY    = froggerPkg::FROG_START_Y;
        for (int k = 0; k < froggerPkg::NUM_CARS; k++)
            mCarX[k] = froggerPkg::CAR_START_X[k];
        mLives    = froggerPkg::START_LIVES;
        mScore    = 0;
        mGameOver = 1'b0;
        mHit      = 1'b0;
    endtask

    task automatic modelTick(input logic [3:0] btn);
        int nx;
        int ny;
        if (!mGameOver)
        begin
            nx     = frogNextX(mFrogX, btn);
            ny     = frogNextY(mFrogY, btn);
            mFrogX = nx;
            mFrogY = ny;
            for (int k = 0; k < froggerPkg::NUM_CARS; k++)
                mCarX[k] = carNext(mCarX[k], k);
        end
        mHit = hitsAt(mFrogX, mFrogY, 1'b0);
        if (!mGameOver)
        begin
            if (mHit)
            begin
                mLives--;
                // Last life leaves the frog in place
                if (mLives == 0)
                    mGameOver = 1'b1;
                else
                begin
                    mFrogX = froggerPkg::FROG_START_X;
                    mFrogY = froggerPkg::FROG_START_Y;
                end
            end
            else if (mFrogY == froggerPkg::GOAL_Y)
            begin
                mScore = (mScore + 1) % 256;
                mFrogX = froggerPkg::FROG_START_X;
                mFrogY = froggerPkg::FROG_START_Y;
            end
        end
    endtask

    ////////////////////
    // Checks and drive
    ////////////////////

    task automatic checkVal(input string what, input logic [31:0] got, input int exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            errCount++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic noteFailure(input string msg);
        errCount++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic checkState();
        checkVal("frog X", o_frogX, mFrogX);
        checkVal("frog Y", o_frogY, mFrogY);
        for (int k = 0; k < froggerPkg::NUM_CARS; k++)
            checkVal($sformatf("car %0d X", k), o_carX[k], mCarX[k]);
        checkVal("lives", o_lives, mLives);
        checkVal("score", o_score, mScore);
        checkVal("game over", o_gameOver, int'(mGameOver));
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("test %s finished with %0d errors", name, errCount - errBefore);
    endtask

    task automatic applyReset();
        @(posedge i_Clk);
        i_rst   <= 1'b1;
        i_tick  <= 1'b0;
        i_up    <= 1'b0;
        i_down  <= 1'b0;
        i_left  <= 1'b0;
        i_right <= 1'b0;
        repeat (5) @(posedge i_Clk);
        i_rst <= 1'b0;
        modelReset();
    endtask

    // Tick at cycle t with hit check at t+2 and state check at t+4
    // Eight cycles per call
    task automatic doTick(input logic [3:0] btn);
        @(posedge i_Clk);
        i_tick  <= 1'b1;
        i_up    <= btn[3];
        i_down  <= btn[2];
        i_left  <= btn[1];
        i_right <= btn[0];
        modelTick(btn);
        @(posedge i_Clk);
        i_tick  <= 1'b0;
        i_up    <= 1'b0;
        i_down  <= 1'b0;
        i_left  <= 1'b0;
        i_right <= 1'b0;
        @(posedge i_Clk);
        @(negedge i_Clk);
        checkVal("hit", o_hit, int'(mHit));
        repeat (2) @(posedge i_Clk);
        @(negedge i_Clk);
        checkState();
        repeat (3) @(posedge i_Clk);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic testReset();
        int errBefore;
        errBefore = errCount;
        applyReset();
        @(negedge i_Clk);
        checkState();
        checkVal("hit", o_hit, 0);
        checkVal("respawn", dut_i.respawn, 0);
        reportTest("reset", errBefore);
    endtask

    // Clamps on both sides and at the bottom within the bottom rows
    task automatic testFrogWalk();
        int errBefore;
        errBefore = errCount;
        applyReset();
        repeat (11) doTick(BTN_LEFT);
        repeat (21) doTick(BTN_RIGHT);
        doTick(BTN_UP);
        repeat (3) doTick(BTN_DOWN);
        reportTest("frogWalk", errBefore);
    endtask

    task automatic testCarWrap();
        int errBefore;
        errBefore = errCount;
        applyReset();
        repeat (200) doTick(BTN_NONE);
        reportTest("carWrap", errBefore);
    endtask

    task automatic testRandomPlay();
        int errBefore;
        int sel;
        errBefore = errCount;
        applyReset();
        for (int n = 0; n < 120; n++)
        begin
            rngState = xorshift(rngState);
            sel      = int'(rngState % 32'd20);
            // Biased upward so the frog reaches the lanes
            if (sel < 8)
                doTick(BTN_UP);
            else if (sel < 11)
                doTick(BTN_DOWN);
            else if (sel < 15)
                doTick(BTN_LEFT);
            else if (sel < 19)
                doTick(BTN_RIGHT);
            else
                doTick(BTN_NONE);
        end
        reportTest("randomPlay", errBefore);
    endtask

    task automatic testReachGoal();
        int errBefore;
        int n;
        errBefore = errCount;
        applyReset();
        n = 0;
        while (mScore == 0 && n < GOAL_LIMIT)
        begin
            doTick(pickMove(1'b0, BTN_UP));
            n++;
        end
        if (mScore == 0)
            noteFailure("frog never reached the goal row within the tick limit");
        checkVal("goal score", o_score, 1);
        reportTest("reachGoal", errBefore);
    endtask

    task automatic testGameOver();
        int                     errBefore;
        int                     n;
        froggerPkg::xPos_t      frogHold;
        froggerPkg::carPosArr_t carsHold;
        errBefore = errCount;
        applyReset();
        n = 0;
        while (!mGameOver && n < KILL_LIMIT)
        begin
            // Wait in a lane for a car and climb elsewhere
            if (mFrogY >= froggerPkg::LANE_Y[0] && mFrogY < froggerPkg::LANE_Y[3] + TILE)
                doTick(pickMove(1'b1, BTN_NONE));
            else
                doTick(BTN_UP);
            n++;
        end
        if (!mGameOver)
            noteFailure("game over never reached within the tick limit");
        checkVal("game over flag", o_gameOver, 1);
        frogHold = o_frogX;
        carsHold = o_carX;
        // Direction the clamp would not block
        repeat (FROZEN_TICKS) doTick((mFrogX >= TILE) ? BTN_LEFT : BTN_RIGHT);
        checkVal("frozen frog X", o_frogX, int'(frogHold));
        checkVal("frozen cars", int'(o_carX === carsHold), 1);
        reportTest("gameOver", errBefore);
    endtask

    ////////////////////
    // Main and watchdog
    ////////////////////

    initial
    begin
        i_rst      = 1'b1;
        i_tick     = 1'b0;
        i_up       = 1'b0;
        i_down     = 1'b0;
        i_left     = 1'b0;
        i_right    = 1'b0;
        errCount   = 0;
        checkCount = 0;
        rngState   = 32'h6aef_89b9;
        modelReset();
        testReset();
        testFrogWalk();
        testCarWrap();
        testRandomPlay();
        testReachGoal();
        testGameOver();
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errCount, dut_i.chk_i.failCount);
        if (errCount == 0 && dut_i.chk_i.failCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* froggerPkg.sv */
// Frogger playfield package with field geometry, lane tables and shared types
`default_nettype none

package froggerPkg;

    ////////////////////
    // Field geometry
    ////////////////////

    // Edge length of frog and car sprites
    localparam int TILE_SIZE = 32;
    // Car X wraps modulo the field width
    localparam int FIELD_W = 640;
    // Frog clamp limits, top-left corner
    localparam int FROG_X_MAX = 608;
    localparam int FROG_Y_MAX = 448;
    // Respawn position, bottom row centered
    localparam int FROG_START_X = 288;
    localparam int FROG_START_Y = 448;
    // Scoring row
    localparam int GOAL_Y = 0;

    ////////////////////
    // Lanes and cars
    ////////////////////

    localparam int NUM_LANES = 4;
    // Two cars per lane, car k sits in lane k/2
    localparam int NUM_CARS = 8;
    // Top row of each lane
    localparam int LANE_Y [NUM_LANES] = '{128, 192, 256, 320};
    // Pixels per tick
    localparam int LANE_SPEED [NUM_LANES] = '{4, 8, 4, 16};
    // Bit per lane, set = moves right (lanes 0 and 2)
    localparam logic [NUM_LANES-1:0] LANE_DIR_RIGHT = 4'b0101;
    localparam int CAR_START_X [NUM_CARS] = '{0, 320, 100, 420, 200, 520, 50, 370};

    // Lives after reset
    localparam int START_LIVES = 3;

    ////////////////////
    // Shared types
    ////////////////////

    typedef logic [9:0] xPos_t;
    typedef logic [8:0] yPos_t;
    // One X per car, element k is car k
    typedef xPos_t [NUM_CARS-1:0] carPosArr_t;
    typedef logic [1:0] lives_t;
    typedef logic [7:0] score_t;

endpackage

`default_nettype wire

/* gameState.sv */
// Game state tracking lives, score, respawn requests, game over and the step tick
`timescale 1ns/1ps
`default_nettype none

module gameState (
    input  wire logic               i_Clk,
    input  wire logic               i_rst,
    // External tick pulse
    input  wire logic               i_tick,
    // Registered hit from collision checker
    input  wire logic               i_hit,
    input  wire froggerPkg::yPos_t  i_frogY,
    output logic                    o_stepTick,
    output logic                    o_respawn,
    output froggerPkg::lives_t      o_lives,
    output froggerPkg::score_t      o_score,
    output logic                    o_gameOver
);

    logic hitPrev;
    logic hitRise;
    logic atGoal;
    logic atGoalReg;
    logic atGoalPrev;
    logic goalRise;

    ////////////////////
    // Edge detection
    ////////////////////

    assign atGoal = (int'(i_frogY) == froggerPkg::GOAL_Y);

    // Goal goes through one extra register, same latency as the hit path
    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            hitPrev    <= 1'b0;
            atGoalReg  <= 1'b0;
            atGoalPrev <= 1'b0;
        end
        else
        begin
            hitPrev    <= i_hit;
            atGoalReg  <= atGoal;
            atGoalPrev <= atGoalReg;
        end
    end

    assign hitRise  = i_hit & ~hitPrev;
    assign goalRise = atGoalReg & ~atGoalPrev;

    ////////////////////
    // Lives and score
    ////////////////////

    always_ff @(posedge i_Clk)
    begin
        if (i_rst)
        begin
            o_lives    <= froggerPkg::lives_t'(froggerPkg::START_LIVES);
            o_score    <= '0;
            o_respawn  <= 1'b0;
            o_gameOver <= 1'b0;
        end
        else
        begin
            // Pulse by default low
            o_respawn <= 1'b0;
            if (!o_gameOver)
            begin
                if (hitRise)
                begin
                    o_lives <= o_lives - 2'd1;
                    // Last life, frog stays where it died
                    if (o_lives == 2'd1)
                        o_gameOver <= 1'b1;
                    else
                        o_respawn <= 1'b1;
                end
                else if (goalRise)
                begin
                    // Wraps at 256
                    o_score   <= o_score + 8'd1;
                    o_respawn <= 1'b1;
                end
            end
        end
    end

    // All motion frozen after game over
    assign o_stepTick = i_tick & ~o_gameOver;

endmodule

`default_nettype wire
